// File: src/ob_pkg.sv
/* book sizes, field widths and codes shared by every block of the order book
   BOOK_DEPTH entries per stock and side, op code 3 is reserved and never accepted */
package ob_pkg;

    // book geometry
    localparam int NUM_STOCKS = 4;
    localparam int BOOK_DEPTH = 8;

    localparam int STOCK_W = $clog2(NUM_STOCKS);
    localparam int SLOT_W  = $clog2(BOOK_DEPTH);
    localparam int COUNT_W = SLOT_W + 1;

    // order fields
    localparam int QTY_W   = 16;
    localparam int PRICE_W = 32;
    localparam int ID_W    = 32;

    typedef enum logic [1:0] {
        OP_ADD     = 2'd0,
        OP_CANCEL  = 2'd1,
        OP_EXECUTE = 2'd2,
        OP_ILLEGAL = 2'd3
    } op_e;

    typedef enum logic {
        SIDE_BID = 1'b0,
        SIDE_ASK = 1'b1
    } side_e;

    typedef enum logic [1:0] {
        ST_OK        = 2'd0,
        ST_FULL      = 2'd1,
        ST_NOT_FOUND = 2'd2
    } status_e;

    // one resting order
    typedef struct packed {
        logic [QTY_W-1:0]   qty;
        logic [PRICE_W-1:0] price;
        logic [ID_W-1:0]    id;
    } book_entry_t;

endpackage

// File: src/order_cmd_if.sv
/* one decoded order from the decoder to the engine and its outcome back
   fields hold steady from start until done */
`timescale 1ns/1ns

interface order_cmd_if;

    logic                           start;
    ob_pkg::op_e                    op;
    ob_pkg::side_e                  side;
    logic [ob_pkg::STOCK_W-1:0]     stock;
    logic [ob_pkg::QTY_W-1:0]       quantity;
    logic [ob_pkg::PRICE_W-1:0]     price;
    logic [ob_pkg::ID_W-1:0]        order_id;
    // outcome
    logic                           done;
    ob_pkg::status_e                status;

    modport decoder (
        output start, op, side, stock, quantity, price, order_id,
        input  done, status
    );

    modport engine (
        input  start, op, side, stock, quantity, price, order_id,
        output done, status
    );

endinterface

// File: src/book_scan_if.sv
/* read port into the book for the best price scanner
   entry and count come back in the same cycle as side and slot */
`timescale 1ns/1ns

interface book_scan_if;

    logic                           scan_start;
    logic [ob_pkg::STOCK_W-1:0]     scan_stock;
    ob_pkg::side_e                  rd_side;
    logic [ob_pkg::SLOT_W-1:0]      rd_slot;
    ob_pkg::book_entry_t            rd_entry;
    logic [ob_pkg::COUNT_W-1:0]     rd_count;
    logic                           scan_done;

    modport engine (
        output scan_start, scan_stock, rd_entry, rd_count,
        input  rd_side, rd_slot, scan_done
    );

    modport scanner (
        input  scan_start, scan_stock, rd_entry, rd_count,
        output rd_side, rd_slot, scan_done
    );

endinterface

// File: src/order_decode.sv
/* takes one order at a time; illegal op codes are dropped without busy or result
   result stays valid until i_consumer_ready is seen high */
`timescale 1ns/1ns

module order_decode (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_order_valid,
    input  logic [1:0]                  i_order_op,
    input  logic                        i_side,
    input  logic [ob_pkg::STOCK_W-1:0]  i_stock_id,
    input  logic [ob_pkg::QTY_W-1:0]    i_quantity,
    input  logic [ob_pkg::PRICE_W-1:0]  i_price,
    input  logic [ob_pkg::ID_W-1:0]     i_order_id,
    input  logic                        i_consumer_ready,
    order_cmd_if.decoder                cmd,
    output logic                        o_book_busy,
    output logic                        o_result_valid,
    output logic [1:0]                  o_status
);

    typedef enum logic [1:0] {D_IDLE, D_WORK, D_HOLD} dec_state_e;

    dec_state_e      state;
    ob_pkg::status_e status_q;
    logic            accept;

    assign accept = (state == D_IDLE) && i_order_valid &&
                    (ob_pkg::op_e'(i_order_op) != ob_pkg::OP_ILLEGAL);

    assign o_book_busy    = (state != D_IDLE);
    assign o_result_valid = (state == D_HOLD);
    assign o_status       = status_q;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state     <= D_IDLE;
            cmd.start <= 1'b0;
        end else begin
            // engine is idle whenever we accept
            cmd.start <= accept;
            case (state)
                D_IDLE: if (accept) state <= D_WORK;
                D_WORK: if (cmd.done) state <= D_HOLD;
                D_HOLD: if (i_consumer_ready) state <= D_IDLE;
                default: state <= D_IDLE;
            endcase
        end
    end

    // order fields and result held for the engine and the consumer
    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd.op       <= ob_pkg::op_e'(i_order_op);
            cmd.side     <= ob_pkg::side_e'(i_side);
            cmd.stock    <= i_stock_id;
            cmd.quantity <= i_quantity;
            cmd.price    <= i_price;
            cmd.order_id <= i_order_id;
        end
        if (state == D_WORK && cmd.done) status_q <= cmd.status;
    end

    a_done_in_work: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        cmd.done |-> state == D_WORK);

endmodule

// File: src/book_engine.sv
/* entries of each stock and side stay packed in slots 0 to count-1
   cancel and execute search the bid list first, then the ask list */
`timescale 1ns/1ns

module book_engine (
    input  logic         i_clk,
    input  logic         i_reset_n,
    order_cmd_if.engine  cmd,
    book_scan_if.engine  scan
);

    typedef enum logic [2:0] {
        E_IDLE,
        E_ADD,
        E_SEARCH,
        E_SHIFT,
        E_SCAN,
        E_WAIT
    } eng_state_e;

    // side index 0 is bid and 1 is ask
    ob_pkg::book_entry_t          mem [2][ob_pkg::NUM_STOCKS][ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::COUNT_W-1:0]   cnt [2][ob_pkg::NUM_STOCKS];

    eng_state_e                   state;
    logic                         srch_side;
    logic [ob_pkg::SLOT_W-1:0]    ptr;
    logic [ob_pkg::SLOT_W-1:0]    ptr_nxt;
    logic [ob_pkg::COUNT_W-1:0]   ptr_ext;
    logic [ob_pkg::COUNT_W-1:0]   add_cnt;
    logic [ob_pkg::COUNT_W-1:0]   cur_cnt;
    ob_pkg::book_entry_t          cur;
    ob_pkg::book_entry_t          new_entry;
    logic                         hit;
    logic                         last;

    assign new_entry = '{qty: cmd.quantity, price: cmd.price, id: cmd.order_id};
    assign add_cnt   = cnt[cmd.side][cmd.stock];

    // current slot of the list being searched or shifted
    assign cur     = mem[srch_side][cmd.stock][ptr];
    assign cur_cnt = cnt[srch_side][cmd.stock];
    assign ptr_nxt = ptr + 1'b1;
    assign ptr_ext = {1'b0, ptr};
    assign hit     = (ptr_ext < cur_cnt) && (cur.id == cmd.order_id);
    assign last    = (ptr_ext + 1'b1 >= cur_cnt);

    // scanner read port
    assign scan.scan_stock = cmd.stock;
    assign scan.rd_entry   = mem[scan.rd_side][scan.scan_stock][scan.rd_slot];
    assign scan.rd_count   = cnt[scan.rd_side][scan.scan_stock];
    assign scan.scan_start = (state == E_SCAN);

    assign cmd.done = (state == E_WAIT) && scan.scan_done;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state <= E_IDLE;
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < ob_pkg::NUM_STOCKS; k++) begin
                    cnt[s][k] <= '0;
                end
            end
        end else begin
            case (state)
                E_IDLE: begin
                    if (cmd.start) begin
                        srch_side <= 1'b0;
                        ptr       <= '0;
                        state     <= (cmd.op == ob_pkg::OP_ADD) ? E_ADD : E_SEARCH;
                    end
                end
                E_ADD: begin
                    if (add_cnt == ob_pkg::COUNT_W'(ob_pkg::BOOK_DEPTH)) begin
                        cmd.status <= ob_pkg::ST_FULL;
                    end else begin
                        mem[cmd.side][cmd.stock][add_cnt[ob_pkg::SLOT_W-1:0]] <= new_entry;
                        cnt[cmd.side][cmd.stock] <= add_cnt + 1'b1;
                        cmd.status <= ob_pkg::ST_OK;
                    end
                    state <= E_SCAN;
                end
                E_SEARCH: begin
                    if (hit) begin
                        cmd.status <= ob_pkg::ST_OK;
                        // partial fill keeps the entry in place
                        if (cmd.op == ob_pkg::OP_EXECUTE && cmd.quantity < cur.qty) begin
                            mem[srch_side][cmd.stock][ptr].qty <= cur.qty - cmd.quantity;
                            state <= E_SCAN;
                        end else begin
                            state <= E_SHIFT;
                        end
                    end else if (!last) begin
                        ptr <= ptr_nxt;
                    end else if (srch_side == 1'b0) begin
                        srch_side <= 1'b1;
                        ptr       <= '0;
                    end else begin
                        cmd.status <= ob_pkg::ST_NOT_FOUND;
                        state      <= E_SCAN;
                    end
                end
                E_SHIFT: begin
                    // close the gap one slot per cycle
                    if (!last) begin
                        mem[srch_side][cmd.stock][ptr] <= mem[srch_side][cmd.stock][ptr_nxt];
                        ptr <= ptr_nxt;
                    end else begin
                        cnt[srch_side][cmd.stock] <= cur_cnt - 1'b1;
                        state <= E_SCAN;
                    end
                end
                E_SCAN: state <= E_WAIT;
                E_WAIT: if (scan.scan_done) state <= E_IDLE;
                default: state <= E_IDLE;
            endcase
        end
    end

    for (genvar s = 0; s < 2; s++) begin : g_side
        for (genvar k = 0; k < ob_pkg::NUM_STOCKS; k++) begin : g_stock
            a_cnt_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
                cnt[s][k] <= ob_pkg::COUNT_W'(ob_pkg::BOOK_DEPTH));
        end
    end

endmodule

// File: src/best_price_scan.sv
/* fixed length scan that visits every slot of both sides once per run
   an empty side reports a price of 0 */
`timescale 1ns/1ns

module best_price_scan (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    book_scan_if.scanner                scan,
    output logic [ob_pkg::PRICE_W-1:0]  o_best_bid,
    output logic [ob_pkg::PRICE_W-1:0]  o_best_ask
);

    typedef enum logic [1:0] {S_IDLE, S_BID, S_ASK} scan_state_e;

    scan_state_e                  state;
    logic [ob_pkg::SLOT_W-1:0]    slot;
    logic [ob_pkg::PRICE_W-1:0]   max_bid;
    logic [ob_pkg::PRICE_W-1:0]   min_ask;
    logic [ob_pkg::PRICE_W-1:0]   bid_next;
    logic [ob_pkg::PRICE_W-1:0]   ask_next;
    logic                         in_range;
    logic                         slot_last;

    assign scan.rd_side = (state == S_ASK) ? ob_pkg::SIDE_ASK : ob_pkg::SIDE_BID;
    assign scan.rd_slot = slot;
    assign in_range     = ({1'b0, slot} < scan.rd_count);
    assign slot_last    = (slot == ob_pkg::SLOT_W'(ob_pkg::BOOK_DEPTH - 1));

    always_comb begin
        bid_next = max_bid;
        ask_next = min_ask;
        if (in_range && state == S_BID && scan.rd_entry.price > max_bid) begin
            bid_next = scan.rd_entry.price;
        end
        if (in_range && state == S_ASK && scan.rd_entry.price < min_ask) begin
            ask_next = scan.rd_entry.price;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state          <= S_IDLE;
            slot           <= '0;
            scan.scan_done <= 1'b0;
            o_best_bid     <= '0;
            o_best_ask     <= '0;
        end else begin
            scan.scan_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (scan.scan_start) begin
                        state   <= S_BID;
                        slot    <= '0;
                        max_bid <= '0;
                        min_ask <= '1;
                    end
                end
                S_BID: begin
                    max_bid <= bid_next;
                    slot    <= slot + 1'b1;
                    if (slot_last) state <= S_ASK;
                end
                S_ASK: begin
                    min_ask <= ask_next;
                    slot    <= slot + 1'b1;
                    if (slot_last) begin
                        o_best_bid     <= max_bid;
                        o_best_ask     <= (scan.rd_count == '0) ? '0 : ask_next;
                        scan.scan_done <= 1'b1;
                        state          <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_start_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        scan.scan_start |-> state == S_IDLE);

endmodule

// File: src/order_book.sv
/* limit order book for NUM_STOCKS stocks, one order in flight at a time
   best prices and status are valid only while o_result_valid is high */
`timescale 1ns/1ns

module order_book (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_order_valid,
    input  logic [1:0]                  i_order_op,
    input  logic                        i_side,
    input  logic [ob_pkg::STOCK_W-1:0]  i_stock_id,
    input  logic [ob_pkg::QTY_W-1:0]    i_quantity,
    input  logic [ob_pkg::PRICE_W-1:0]  i_price,
    input  logic [ob_pkg::ID_W-1:0]     i_order_id,
    input  logic                        i_consumer_ready,
    output logic                        o_book_busy,
    output logic                        o_result_valid,
    output logic [1:0]                  o_status,
    output logic [ob_pkg::PRICE_W-1:0]  o_best_bid,
    output logic [ob_pkg::PRICE_W-1:0]  o_best_ask
);

    order_cmd_if cmd_if ();
    book_scan_if scan_if ();

    order_decode decode_i (
        .i_clk            (i_clk),
        .i_reset_n        (i_reset_n),
        .i_order_valid    (i_order_valid),
        .i_order_op       (i_order_op),
        .i_side           (i_side),
        .i_stock_id       (i_stock_id),
        .i_quantity       (i_quantity),
        .i_price          (i_price),
        .i_order_id       (i_order_id),
        .i_consumer_ready (i_consumer_ready),
        .cmd              (cmd_if.decoder),
        .o_book_busy      (o_book_busy),
        .o_result_valid   (o_result_valid),
        .o_status         (o_status)
    );

    book_engine engine_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .cmd       (cmd_if.engine),
        .scan      (scan_if.engine)
    );

    best_price_scan scan_i (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .scan       (scan_if.scanner),
        .o_best_bid (o_best_bid),
        .o_best_ask (o_best_ask)
    );

endmodule

// File: tests/tb_tasks.svh
/* directed tests for the order book, included inside tb_order_book
   every task starts and ends DRIVE_DELAY after a rising clock edge */

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] at %0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
endtask

// presents one order for a single clock edge
task automatic send_order(input logic [1:0] op, input logic side, input int stock,
                          input logic [15:0] qty, input logic [31:0] price,
                          input logic [31:0] id);
    i_order_valid = 1'b1;
    i_order_op    = op;
    i_side        = side;
    i_stock_id    = stock[ob_pkg::STOCK_W-1:0];
    i_quantity    = qty;
    i_price       = price;
    i_order_id    = id;
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_order_valid = 1'b0;
endtask

task automatic wait_result(output bit seen);
    int cycles;
    cycles = 0;
    while (!o_result_valid && cycles < RESULT_LIMIT) begin
        @(posedge i_clk);
        #DRIVE_DELAY;
        cycles++;
    end
    seen = o_result_valid;
    if (!seen) begin
        errors++;
        $display("no result: o_result_valid stayed low for %0d cycles", RESULT_LIMIT);
    end
endtask

task automatic take_result();
    i_consumer_ready = 1'b1;
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_consumer_ready = 1'b0;
    check_value("o_result_valid", 32'(o_result_valid), 32'd0);
    check_value("o_book_busy", 32'(o_book_busy), 32'd0);
endtask

task automatic run_order(input logic [1:0] op, input logic side, input int stock,
                         input logic [15:0] qty, input logic [31:0] price,
                         input logic [31:0] id);
    logic [1:0]  exp_status;
    logic [31:0] exp_bid;
    logic [31:0] exp_ask;
    bit          seen;
    exp_status = model_apply(op, side, stock, qty, price, id);
    exp_bid    = model_best(0, stock);
    exp_ask    = model_best(1, stock);
    send_order(op, side, stock, qty, price, id);
    wait_result(seen);
    if (seen) begin
        check_value("o_status", 32'(o_status), 32'(exp_status));
        check_value("o_best_bid", o_best_bid, exp_bid);
        check_value("o_best_ask", o_best_ask, exp_ask);
        take_result();
    end
endtask

task automatic test_reset_state();
    check_value("o_book_busy", 32'(o_book_busy), 32'd0);
    check_value("o_result_valid", 32'(o_result_valid), 32'd0);
    check_value("o_best_bid", o_best_bid, 32'd0);
    check_value("o_best_ask", o_best_ask, 32'd0);
    // lone bid, the ask side of stock 0 is still empty
    run_order(ob_pkg::OP_ADD, ob_pkg::SIDE_BID, 0, 16'd10, 32'd5000, new_id());
endtask

task automatic test_adds();
    for (int k = 0; k < ob_pkg::NUM_STOCKS; k++) begin
        for (int n = 0; n < 3; n++) begin
            run_order(ob_pkg::OP_ADD, ob_pkg::SIDE_BID, k, 16'($urandom_range(500, 1)),
                      $urandom_range(100000, 1000), new_id());
            run_order(ob_pkg::OP_ADD, ob_pkg::SIDE_ASK, k, 16'($urandom_range(500, 1)),
                      $urandom_range(100000, 1000), new_id());
        end
    end
endtask

task automatic test_full_list();
    // fill the bid list of stock 1, the last add finds it full
    while (m_cnt[0][1] < DEPTH) begin
        run_order(ob_pkg::OP_ADD, ob_pkg::SIDE_BID, 1, 16'd20,
                  $urandom_range(100000, 1000), new_id());
    end
    run_order(ob_pkg::OP_ADD, ob_pkg::SIDE_BID, 1, 16'd20, 32'd999_999, new_id());
endtask

task automatic test_cancel();
    logic [31:0] top_id;
    logic [31:0] mid_id;
    top_id = new_id();
    // above every random bid
    run_order(ob_pkg::OP_ADD, ob_pkg::SIDE_BID, 2, 16'd50, 32'd900_000, top_id);
    run_order(ob_pkg::OP_CANCEL, ob_pkg::SIDE_BID, 2, 16'd0, 32'd0, top_id);
    // middle ask, found only after the bid list is searched
    mid_id = m_id[1][2][1];
    run_order(ob_pkg::OP_CANCEL, ob_pkg::SIDE_ASK, 2, 16'd0, 32'd0, mid_id);
    run_order(ob_pkg::OP_CANCEL, ob_pkg::SIDE_ASK, 2, 16'd0, 32'd0, 32'hdead_beef);
endtask

task automatic test_execute();
    logic [31:0] ask_id;
    ask_id = new_id();
    // below every random ask
    run_order(ob_pkg::OP_ADD, ob_pkg::SIDE_ASK, 3, 16'd100, 32'd50, ask_id);
    run_order(ob_pkg::OP_EXECUTE, ob_pkg::SIDE_ASK, 3, 16'd40, 32'd0, ask_id);
    run_order(ob_pkg::OP_EXECUTE, ob_pkg::SIDE_ASK, 3, 16'd60, 32'd0, ask_id);
    ask_id = new_id();
    run_order(ob_pkg::OP_ADD, ob_pkg::SIDE_ASK, 3, 16'd10, 32'd40, ask_id);
    run_order(ob_pkg::OP_EXECUTE, ob_pkg::SIDE_ASK, 3, 16'd25, 32'd0, ask_id);
endtask

task automatic test_back_pressure();
    logic [1:0]  exp_status;
    logic [31:0] exp_bid;
    logic [31:0] exp_ask;
    logic [31:0] id;
    bit          seen;
    id         = new_id();
    exp_status = model_apply(ob_pkg::OP_ADD, ob_pkg::SIDE_BID, 0, 16'd7, 32'd150_000, id);
    exp_bid    = model_best(0, 0);
    exp_ask    = model_best(1, 0);
    send_order(ob_pkg::OP_ADD, ob_pkg::SIDE_BID, 0, 16'd7, 32'd150_000, id);
    wait_result(seen);
    if (seen) begin
        // second order offered while the first result is held
        i_order_valid = 1'b1;
        i_order_op    = ob_pkg::OP_ADD;
        i_side        = ob_pkg::SIDE_ASK;
        i_price       = 32'd777;
        i_order_id    = new_id();
        repeat (10) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
            check_value("o_result_valid", 32'(o_result_valid), 32'd1);
            check_value("o_book_busy", 32'(o_book_busy), 32'd1);
            check_value("o_status", 32'(o_status), 32'(exp_status));
            check_value("o_best_bid", o_best_bid, exp_bid);
            check_value("o_best_ask", o_best_ask, exp_ask);
        end
        i_order_valid = 1'b0;
        take_result();
        repeat (5) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
            check_value("o_result_valid", 32'(o_result_valid), 32'd0);
            check_value("o_book_busy", 32'(o_book_busy), 32'd0);
        end
    end
endtask

task automatic test_illegal_op();
    send_order(ob_pkg::OP_ILLEGAL, ob_pkg::SIDE_ASK, 1, 16'd5, 32'd1234, new_id());
    repeat (DEPTH) begin
        check_value("o_book_busy", 32'(o_book_busy), 32'd0);
        check_value("o_result_valid", 32'(o_result_valid), 32'd0);
        @(posedge i_clk);
        #DRIVE_DELAY;
    end
endtask

// File: tests/tb_order_book.sv
/* self-checking testbench for the order book, one order in flight at a time
   expected status and best prices come from a behavioral model of the book */
`timescale 1ns/1ns

module tb_order_book;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 10;
    localparam int DEPTH           = ob_pkg::BOOK_DEPTH;
    localparam int STOCKS          = ob_pkg::NUM_STOCKS;
    // orders submitted over all directed tests
    localparam int NUM_ORDERS      = 43;
    localparam int WATCHDOG_CYCLES = NUM_ORDERS * 60;
    // two full searches, a shift and a scan, with some slack
    localparam int RESULT_LIMIT    = 6 * DEPTH + 8;

    logic                        i_clk;
    logic                        i_reset_n;
    logic                        i_order_valid;
    logic [1:0]                  i_order_op;
    logic                        i_side;
    logic [ob_pkg::STOCK_W-1:0]  i_stock_id;
    logic [ob_pkg::QTY_W-1:0]    i_quantity;
    logic [ob_pkg::PRICE_W-1:0]  i_price;
    logic [ob_pkg::ID_W-1:0]     i_order_id;
    logic                        i_consumer_ready;
    logic                        o_book_busy;
    logic                        o_result_valid;
    logic [1:0]                  o_status;
    logic [ob_pkg::PRICE_W-1:0]  o_best_bid;
    logic [ob_pkg::PRICE_W-1:0]  o_best_ask;

    int          errors;
    int          checks;
    logic [31:0] next_id;

    // model of the book, side 0 is bid
    logic [ob_pkg::PRICE_W-1:0]  m_price [2][STOCKS][DEPTH];
    logic [ob_pkg::QTY_W-1:0]    m_qty   [2][STOCKS][DEPTH];
    logic [ob_pkg::ID_W-1:0]     m_id    [2][STOCKS][DEPTH];
    int                          m_cnt   [2][STOCKS];

    order_book dut_i (
        .i_clk            (i_clk),
        .i_reset_n        (i_reset_n),
        .i_order_valid    (i_order_valid),
        .i_order_op       (i_order_op),
        .i_side           (i_side),
        .i_stock_id       (i_stock_id),
        .i_quantity       (i_quantity),
        .i_price          (i_price),
        .i_order_id       (i_order_id),
        .i_consumer_ready (i_consumer_ready),
        .o_book_busy      (o_book_busy),
        .o_result_valid   (o_result_valid),
        .o_status         (o_status),
        .o_best_bid       (o_best_bid),
        .o_best_ask       (o_best_ask)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // close the gap left by a removed entry
    function automatic void model_remove(int s, int k, int slot);
        for (int i = slot; i < m_cnt[s][k] - 1; i++) begin
            m_price[s][k][i] = m_price[s][k][i+1];
            m_qty[s][k][i]   = m_qty[s][k][i+1];
            m_id[s][k][i]    = m_id[s][k][i+1];
        end
        m_cnt[s][k]--;
    endfunction

    function automatic logic [1:0] model_apply(logic [1:0] op, logic side, int k,
                                               logic [15:0] qty, logic [31:0] price,
                                               logic [31:0] id);
        int s;
        s = int'(side);
        if (op == ob_pkg::OP_ADD) begin
            if (m_cnt[s][k] == DEPTH) begin
                return ob_pkg::ST_FULL;
            end
            m_price[s][k][m_cnt[s][k]] = price;
            m_qty[s][k][m_cnt[s][k]]   = qty;
            m_id[s][k][m_cnt[s][k]]    = id;
            m_cnt[s][k]++;
            return ob_pkg::ST_OK;
        end
        // id search ignores the side of the order, bid list first
        for (int t = 0; t < 2; t++) begin
            for (int i = 0; i < m_cnt[t][k]; i++) begin
                if (m_id[t][k][i] == id) begin
                    if (op == ob_pkg::OP_EXECUTE && qty < m_qty[t][k][i]) begin
                        m_qty[t][k][i] = m_qty[t][k][i] - qty;
                    end else begin
                        model_remove(t, k, i);
                    end
                    return ob_pkg::ST_OK;
                end
            end
        end
        return ob_pkg::ST_NOT_FOUND;
    endfunction

    // highest bid or lowest ask, 0 for an empty side
    function automatic logic [31:0] model_best(int s, int k);
        logic [31:0] best;
        best = (s == 0) ? 32'h0 : 32'hffff_ffff;
        if (m_cnt[s][k] == 0) begin
            return 32'h0;
        end
        for (int i = 0; i < m_cnt[s][k]; i++) begin
            if ((s == 0 && m_price[s][k][i] > best) || (s == 1 && m_price[s][k][i] < best)) begin
                best = m_price[s][k][i];
            end
        end
        return best;
    endfunction

    function automatic logic [31:0] new_id();
        next_id++;
        return next_id;
    endfunction

    `include "tb_tasks.svh"

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        i_reset_n        = 1'b0;
        i_order_valid    = 1'b0;
        i_order_op       = '0;
        i_side           = 1'b0;
        i_stock_id       = '0;
        i_quantity       = '0;
        i_price          = '0;
        i_order_id       = '0;
        i_consumer_ready = 1'b0;
        errors           = 0;
        checks           = 0;
        next_id          = 32'h100;
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < STOCKS; k++) begin
                m_cnt[s][k] = 0;
            end
        end
        void'($urandom(32'hfbf6_ddab));
        repeat (3) @(posedge i_clk);
        #DRIVE_DELAY;
        i_reset_n = 1'b1;

        test_reset_state();
        test_adds();
        test_full_list();
        test_cancel();
        test_execute();
        test_back_pressure();
        test_illegal_op();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+tests
src/ob_pkg.sv
src/order_cmd_if.sv
src/book_scan_if.sv
src/order_decode.sv
src/book_engine.sv
src/best_price_scan.sv
src/order_book.sv
tests/tb_order_book.sv

// File: Makefile
# Verilator flow for the order book, every variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= tb_order_book
RTL_TOP   ?= order_book
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_FILES ?= src/ob_pkg.sv src/order_cmd_if.sv src/book_scan_if.sv src/order_decode.sv \
             src/book_engine.sv src/best_price_scan.sv src/order_book.sv

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
